// File: src/chipset_pkg.sv
`default_nettype none

package chipset_pkg;

	// meaningful widths
	typedef logic [19:0] cpu_addr_t;
	typedef logic [7:0] data_t;
	typedef logic [20:0] sram_addr_t;
	typedef logic [5:0] ems_page_t;
	// frame 0 lives in bits 23:18
	typedef logic [23:0] ems_map_t;
	// bit k enables frame k
	typedef logic [3:0] ems_ena_t;

	// fixed i/o ports
	localparam logic [15:0] LPT_PORT = 16'h0378;
	localparam logic [15:0] TANDY_PAGE_PORT = 16'h03DF;
	// eight-port block, low three bits ignored
	localparam logic [15:0] NMI_MASK_BASE = 16'h00A0;
	// four-port block, one register per frame
	localparam logic [15:0] EMS_PORT_BASE = 16'h0260;

	// ems write encodings
	localparam data_t EMS_DISABLE_VALUE = 8'hFF;
	localparam data_t EMS_KEEP_THRESHOLD = 8'h80;

	// memory windows, matched on the top address bits
	localparam logic [4:0] CGA_WINDOW_TAG = 5'b10111;
	localparam logic [6:0] BIOS_TAG = 7'b1111111;
	// segment D belongs to option roms, not ram
	localparam logic [3:0] ROM_SEGMENT_TAG = 4'b1101;
	// where video memory sits in sram
	localparam logic [5:0] CGA_SRAM_BASE = 6'b010111;

	// latch power-up values
	localparam data_t LPT_RESET = 8'hFF;
	localparam data_t NMI_MASK_RESET = 8'hFF;
	localparam data_t TANDY_PAGE_RESET = 8'h00;

	// cpu side of the bus, strobes active low
	typedef struct packed {
		cpu_addr_t address;
		data_t data;
		logic io_read_n;
		logic io_write_n;
		logic memory_read_n;
		logic memory_write_n;
		logic address_enable_n;
	} cpu_bus_t;

	// decoded selects, all active high
	typedef struct packed {
		logic lpt;
		logic tandy_page;
		logic nmi_mask;
		logic ems_regs;
		logic cga_window;
		logic ram;
		// any i/o strobe low
		logic io_request;
	} select_t;

endpackage

`default_nettype wire

// File: src/io_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module io_decoder (
	input wire chipset_pkg::cpu_bus_t bus_i,
	input wire tandy_video_i,
	input wire ems_enabled_i,
	output chipset_pkg::select_t select_o,
	output logic dma_chip_select_n_o,
	output logic dma_page_chip_select_n_o
);
	import chipset_pkg::*;

	logic iorq;
	logic io_cycle;
	logic mem_cycle;
	logic low_window;
	logic [2:0] slot;

	assign iorq = !bus_i.io_read_n || !bus_i.io_write_n;
	assign io_cycle = iorq && !bus_i.address_enable_n;
	assign mem_cycle = !iorq && !bus_i.address_enable_n;

	// first 256 ports, cut into 32-port slots
	assign low_window = bus_i.address[9:8] == 2'b00;
	assign slot = bus_i.address[7:5];

	// slot 0 is the dma controller, slot 4 its page registers
	assign dma_chip_select_n_o = !(io_cycle && low_window && slot == 3'd0);
	assign dma_page_chip_select_n_o = !(io_cycle && low_window && slot == 3'd4);

	always_comb begin
		select_t sel;

		sel.io_request = iorq;
		sel.lpt = io_cycle && bus_i.address[15:0] == LPT_PORT;
		sel.tandy_page = io_cycle && bus_i.address[15:0] == TANDY_PAGE_PORT;
		// only present on tandy video
		sel.nmi_mask = io_cycle && tandy_video_i &&
			bus_i.address[15:3] == NMI_MASK_BASE[15:3];
		sel.ems_regs = io_cycle && ems_enabled_i &&
			bus_i.address[15:2] == EMS_PORT_BASE[15:2];

		// memory windows
		sel.cga_window = mem_cycle && bus_i.address[19:15] == CGA_WINDOW_TAG;
		sel.ram = mem_cycle &&
			bus_i.address[19:13] != BIOS_TAG &&
			bus_i.address[19:16] != ROM_SEGMENT_TAG;

		// cga window sits inside ram, so it is left out of the check
		if (!$isunknown({bus_i, tandy_video_i, ems_enabled_i})) begin
			assert ($onehot0({sel.lpt, sel.tandy_page, sel.nmi_mask, sel.ems_regs, sel.ram}))
				else $error("io_decoder: more than one select active");
		end

		select_o = sel;
	end

endmodule

`default_nettype wire

// File: src/ems_mapper.sv
`timescale 1ns/1ps
`default_nettype none

module ems_mapper (
	input wire clock,
	input wire reset,
	input wire chipset_pkg::cpu_bus_t bus_i,
	input wire chipset_pkg::select_t select_i,
	input wire [1:0] ems_address_i,
	output logic hit_o,
	output chipset_pkg::ems_page_t page_o,
	output chipset_pkg::data_t read_data_o
);
	import chipset_pkg::*;

	ems_map_t map_q;
	ems_ena_t ena_q;
	logic wr_pending_q;
	logic [1:0] wr_offset_q;
	ems_page_t wr_page_q;
	logic wr_ena_q;
	logic wr_req;
	logic [1:0] offset;
	logic [1:0] frame;
	logic [3:0] segment;
	ems_page_t cur_page;
	logic cur_ena;
	ems_page_t new_page;
	logic new_ena;

	// frame 0 is the top slice of the map
	function automatic ems_page_t page_of(input ems_map_t map, input logic [1:0] idx);
		return map[(3 - idx) * 6 +: 6];
	endfunction

	assign offset = bus_i.address[1:0];
	assign frame = bus_i.address[15:14];
	assign wr_req = select_i.ems_regs && !bus_i.io_write_n;

	// a write still in the pipeline is newer than the map
	always_comb begin
		if (wr_pending_q && wr_offset_q == offset) begin
			cur_page = wr_page_q;
			cur_ena = wr_ena_q;
		end else begin
			cur_page = page_of(map_q, offset);
			cur_ena = ena_q[offset];
		end
	end

	// 0xff disables, below 0x80 maps, anything else keeps
	always_comb begin
		new_page = cur_page;
		new_ena = cur_ena;
		if (bus_i.data == EMS_DISABLE_VALUE) begin
			new_page = ems_page_t'(EMS_DISABLE_VALUE);
			new_ena = 1'b0;
		end else if (bus_i.data < EMS_KEEP_THRESHOLD) begin
			new_page = bus_i.data[5:0];
			new_ena = 1'b1;
		end
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			wr_pending_q <= 1'b0;
			ena_q <= '0;
		end else begin
			wr_pending_q <= wr_req;
			if (wr_pending_q)
				ena_q[wr_offset_q] <= wr_ena_q;
		end
	end

	// captured at the write edge, committed one edge later
	always_ff @(posedge clock) begin
		if (wr_req) begin
			wr_offset_q <= offset;
			wr_page_q <= new_page;
			wr_ena_q <= new_ena;
		end
		if (wr_pending_q)
			map_q[(3 - wr_offset_q) * 6 +: 6] <= wr_page_q;
	end

	// page frame segment
	always_comb begin
		case (ems_address_i)
			2'd0: segment = 4'hA;
			2'd1: segment = 4'hC;
			default: segment = 4'hD;
		endcase
	end

	assign hit_o = !select_i.io_request && bus_i.address[19:16] == segment && ena_q[frame];
	assign page_o = page_of(map_q, frame);
	assign read_data_o = ena_q[offset] ? {2'b00, page_of(map_q, offset)} : EMS_DISABLE_VALUE;

	// mapping must never steer an i/o cycle
	assert property (@(posedge clock) disable iff (reset)
		!(hit_o && (!bus_i.io_read_n || !bus_i.io_write_n)))
		else $error("ems_mapper: frame hit during i/o cycle");

endmodule

`default_nettype wire

// File: src/latch_registers.sv
`timescale 1ns/1ps
`default_nettype none

module latch_registers (
	input wire clock,
	input wire reset,
	input wire chipset_pkg::cpu_bus_t bus_i,
	input wire chipset_pkg::select_t select_i,
	output chipset_pkg::data_t lpt_o,
	output chipset_pkg::data_t tandy_page_o,
	output chipset_pkg::data_t nmi_mask_o
);
	import chipset_pkg::*;

	logic io_write;

	assign io_write = !bus_i.io_write_n;

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			lpt_o <= LPT_RESET;
			tandy_page_o <= TANDY_PAGE_RESET;
			nmi_mask_o <= NMI_MASK_RESET;
		end else begin
			// printer data latch
			if (select_i.lpt && io_write)
				lpt_o <= bus_i.data;
			// tandy video page, cpu and crtc halves
			if (select_i.tandy_page && io_write)
				tandy_page_o <= bus_i.data;
			// also carries the tandy ram bank bits
			if (select_i.nmi_mask && io_write)
				nmi_mask_o <= bus_i.data;
		end
	end

endmodule

`default_nettype wire

// File: src/mem_address_mapper.sv
`timescale 1ns/1ps
`default_nettype none

module mem_address_mapper (
	input wire chipset_pkg::cpu_bus_t bus_i,
	input wire chipset_pkg::select_t select_i,
	input wire ems_hit_i,
	input wire chipset_pkg::ems_page_t ems_page_i,
	input wire chipset_pkg::data_t tandy_page_i,
	input wire chipset_pkg::data_t nmi_mask_i,
	input wire tandy_16_gfx_i,
	output chipset_pkg::sram_addr_t sram_addr_o,
	output logic sram_we_n_o,
	output chipset_pkg::data_t sram_data_o
);
	import chipset_pkg::*;

	logic page_bit;

	// page bit 3 forces the upper half of the 32k window
	assign page_bit = tandy_page_i[3] ? 1'b1 : bus_i.address[14];

	always_comb begin
		if (ems_hit_i) begin
			// expanded memory lives in the upper megabyte
			sram_addr_o = {1'b1, ems_page_i, bus_i.address[13:0]};
		end else if (select_i.cga_window && tandy_16_gfx_i) begin
			// tandy 16-colour modes page video out of system ram
			sram_addr_o = {1'b0, nmi_mask_i[3:1], tandy_page_i[5:4], page_bit,
				bus_i.address[13:0]};
		end else begin
			sram_addr_o = {1'b0, bus_i.address};
		end
	end

	assign sram_we_n_o = !(select_i.ram && !bus_i.memory_write_n);
	assign sram_data_o = bus_i.data;

endmodule

`default_nettype wire

// File: src/bus_read_mux.sv
`timescale 1ns/1ps
`default_nettype none

module bus_read_mux (
	input wire clock,
	input wire reset,
	input wire chipset_pkg::cpu_bus_t bus_i,
	input wire chipset_pkg::select_t select_i,
	input wire chipset_pkg::data_t sram_data_i,
	input wire chipset_pkg::data_t ems_data_i,
	input wire chipset_pkg::data_t lpt_i,
	input wire chipset_pkg::data_t nmi_mask_i,
	output chipset_pkg::data_t read_data_o,
	output logic read_valid_o
);
	import chipset_pkg::*;

	logic io_read;
	logic mem_read;
	data_t next_data;
	logic next_valid;

	assign io_read = !bus_i.io_read_n;
	assign mem_read = !bus_i.memory_read_n;

	// first match wins
	always_comb begin
		next_data = '0;
		next_valid = 1'b1;
		if (select_i.ram && mem_read)
			next_data = sram_data_i;
		else if (select_i.ems_regs && io_read)
			next_data = ems_data_i;
		else if (select_i.lpt && io_read)
			next_data = lpt_i;
		else if (select_i.nmi_mask && io_read)
			next_data = nmi_mask_i;
		else
			next_valid = 1'b0;
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			read_data_o <= '0;
			read_valid_o <= 1'b0;
		end else begin
			read_data_o <= next_data;
			read_valid_o <= next_valid;
		end
	end

	// the decoder never offers two read sources at once
	assert property (@(posedge clock) disable iff (reset)
		$onehot0({select_i.ram && mem_read, select_i.ems_regs && io_read,
			select_i.lpt && io_read, select_i.nmi_mask && io_read}))
		else $error("bus_read_mux: two read sources in one cycle");

endmodule

`default_nettype wire

// File: src/chipset_core.sv
`timescale 1ns/1ps
`default_nettype none

module chipset_core (
	input wire clock,
	input wire reset,
	input wire chipset_pkg::cpu_bus_t cpu_bus_i,
	input wire ems_enabled_i,
	input wire [1:0] ems_address_i,
	input wire tandy_video_i,
	input wire tandy_16_gfx_i,
	input wire chipset_pkg::data_t sram_data_i,
	output logic dma_chip_select_n_o,
	output logic dma_page_chip_select_n_o,
	output chipset_pkg::sram_addr_t sram_addr_o,
	output logic sram_we_n_o,
	output chipset_pkg::data_t sram_data_o,
	output chipset_pkg::data_t read_data_o,
	output logic read_valid_o
);
	import chipset_pkg::*;

	select_t sel;
	logic ems_hit;
	ems_page_t ems_page;
	data_t ems_data;
	data_t lpt;
	data_t tandy_page;
	data_t nmi_mask;

	io_decoder u_io_decoder (
		.bus_i(cpu_bus_i),
		.tandy_video_i(tandy_video_i),
		.ems_enabled_i(ems_enabled_i),
		.select_o(sel),
		.dma_chip_select_n_o(dma_chip_select_n_o),
		.dma_page_chip_select_n_o(dma_page_chip_select_n_o)
	);

	ems_mapper u_ems_mapper (
		.clock(clock),
		.reset(reset),
		.bus_i(cpu_bus_i),
		.select_i(sel),
		.ems_address_i(ems_address_i),
		.hit_o(ems_hit),
		.page_o(ems_page),
		.read_data_o(ems_data)
	);

	latch_registers u_latch_registers (
		.clock(clock),
		.reset(reset),
		.bus_i(cpu_bus_i),
		.select_i(sel),
		.lpt_o(lpt),
		.tandy_page_o(tandy_page),
		.nmi_mask_o(nmi_mask)
	);

	mem_address_mapper u_mem_address_mapper (
		.bus_i(cpu_bus_i),
		.select_i(sel),
		.ems_hit_i(ems_hit),
		.ems_page_i(ems_page),
		.tandy_page_i(tandy_page),
		.nmi_mask_i(nmi_mask),
		.tandy_16_gfx_i(tandy_16_gfx_i),
		.sram_addr_o(sram_addr_o),
		.sram_we_n_o(sram_we_n_o),
		.sram_data_o(sram_data_o)
	);

	bus_read_mux u_bus_read_mux (
		.clock(clock),
		.reset(reset),
		.bus_i(cpu_bus_i),
		.select_i(sel),
		.sram_data_i(sram_data_i),
		.ems_data_i(ems_data),
		.lpt_i(lpt),
		.nmi_mask_i(nmi_mask),
		.read_data_o(read_data_o),
		.read_valid_o(read_valid_o)
	);

endmodule

`default_nettype wire

// File: tb/chipset_tb.sv
`timescale 1ns/1ps
`default_nettype none

module chipset_tb;
	import chipset_pkg::*;

	typedef enum logic [2:0] {OP_IDLE, OP_IO_RD, OP_IO_WR, OP_MEM_RD, OP_MEM_WR} bus_op_e;

	// mode is {ems_enabled, tandy_video, tandy_16_gfx}
	// strobes are {dma_n, dma_page_n, sram_we_n}
	typedef struct {
		bus_op_e op;
		cpu_addr_t addr;
		data_t data;
		logic [2:0] mode;
		logic exp_valid;
		data_t exp_data;
		sram_addr_t exp_addr;
		logic [2:0] exp_strobes;
	} row_t;

	localparam int RAND_ROUNDS = 8;

	logic clock;
	logic reset;
	cpu_bus_t cpu_bus;
	logic ems_enabled;
	logic [1:0] ems_address;
	logic tandy_video;
	logic tandy_16_gfx;
	data_t sram_data_in;
	logic dma_cs_n;
	logic dma_page_cs_n;
	sram_addr_t sram_addr;
	logic sram_we_n;
	data_t sram_data_out;
	data_t read_data;
	logic read_valid;

	row_t stim_table[$];
	integer seed;
	int error_count = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int cycle_count = 0;
	int cycle_limit = 1000;

	chipset_core DUT (
		.clock(clock),
		.reset(reset),
		.cpu_bus_i(cpu_bus),
		.ems_enabled_i(ems_enabled),
		.ems_address_i(ems_address),
		.tandy_video_i(tandy_video),
		.tandy_16_gfx_i(tandy_16_gfx),
		.sram_data_i(sram_data_in),
		.dma_chip_select_n_o(dma_cs_n),
		.dma_page_chip_select_n_o(dma_page_cs_n),
		.sram_addr_o(sram_addr),
		.sram_we_n_o(sram_we_n),
		.sram_data_o(sram_data_out),
		.read_data_o(read_data),
		.read_valid_o(read_valid)
	);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("timeout: stimulus still running after %0d cycles", cycle_count);
			$display("TEST FAILED");
			$finish;
		end
	end

	function automatic cpu_bus_t make_bus(input bus_op_e op, input cpu_addr_t addr,
			input data_t data);
		cpu_bus_t bus;

		bus.address = addr;
		bus.data = data;
		bus.io_read_n = op != OP_IO_RD;
		bus.io_write_n = op != OP_IO_WR;
		bus.memory_read_n = op != OP_MEM_RD;
		bus.memory_write_n = op != OP_MEM_WR;
		// cpu cycles only, never a dma transfer
		bus.address_enable_n = op == OP_IDLE;
		return bus;
	endfunction

	task automatic check_data(input string name, input data_t got, input data_t exp);
		if (got !== exp) begin
			$display("FAIL t=%0t %s got 0x%02h expected 0x%02h", $time, name, got, exp);
			error_count++;
		end
	endtask

	task automatic check_addr(input string name, input sram_addr_t got, input sram_addr_t exp);
		if (got !== exp) begin
			$display("FAIL t=%0t %s got 0x%06h expected 0x%06h", $time, name, got, exp);
			error_count++;
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("FAIL t=%0t %s got %b expected %b", $time, name, got, exp);
			error_count++;
		end
	endtask

	task automatic add_row(input bus_op_e op, input cpu_addr_t addr, input data_t data,
			input logic [2:0] mode, input logic exp_valid, input data_t exp_data,
			input sram_addr_t exp_addr, input logic [2:0] exp_strobes);
		row_t row;

		row = '{op, addr, data, mode, exp_valid, exp_data, exp_addr, exp_strobes};
		stim_table.push_back(row);
	endtask

	// one access cycle, then an idle cycle that collects the registered read
	task automatic run_access(input string label, input bus_op_e op, input cpu_addr_t addr,
			input data_t data, input logic [2:0] mode, input logic exp_valid,
			input data_t exp_data, input sram_addr_t exp_addr, input logic [2:0] exp_strobes);
		int errors_before;
		data_t bus_data;

		errors_before = error_count;
		// cpu data lines on a memory read differ from the sram byte
		bus_data = (op == OP_MEM_RD) ? ~data : data;
		@(posedge clock);
		cpu_bus <= make_bus(op, addr, bus_data);
		sram_data_in <= data;
		{ems_enabled, tandy_video, tandy_16_gfx} <= mode;
		@(negedge clock);
		check_bit("dma_chip_select_n_o", dma_cs_n, exp_strobes[2]);
		check_bit("dma_page_chip_select_n_o", dma_page_cs_n, exp_strobes[1]);
		check_bit("sram_we_n_o", sram_we_n, exp_strobes[0]);
		check_addr("sram_addr_o", sram_addr, exp_addr);
		check_data("sram_data_o", sram_data_out, bus_data);
		@(posedge clock);
		cpu_bus <= make_bus(OP_IDLE, '0, '0);
		@(negedge clock);
		check_bit("read_valid_o", read_valid, exp_valid);
		check_data("read_data_o", read_data, exp_data);
		tests_run++;
		if (error_count == errors_before) begin
			$display("%s: ok", label);
		end else begin
			tests_failed++;
			$display("%s: mismatch", label);
		end
	endtask

	task automatic load_table();
		// reset state, tandy paging from reset values
		add_row(OP_IDLE, 20'h00000, 8'h00, 3'b110, 1'b0, 8'h00, 21'h000000, 3'b111);
		add_row(OP_IO_RD, 20'h00378, 8'h00, 3'b110, 1'b1, 8'hFF, 21'h000378, 3'b111);
		add_row(OP_IO_RD, 20'h000A0, 8'h00, 3'b110, 1'b1, 8'hFF, 21'h0000A0, 3'b111);
		add_row(OP_MEM_RD, 20'hB8123, 8'h3C, 3'b111, 1'b1, 8'h3C, 21'h0E0123, 3'b111);
		// dma slots 0 and 4
		add_row(OP_IO_WR, 20'h00000, 8'h00, 3'b110, 1'b0, 8'h00, 21'h000000, 3'b011);
		add_row(OP_IO_RD, 20'h0001F, 8'h00, 3'b110, 1'b0, 8'h00, 21'h00001F, 3'b011);
		add_row(OP_IO_WR, 20'h00080, 8'h00, 3'b110, 1'b0, 8'h00, 21'h000080, 3'b101);
		add_row(OP_IO_RD, 20'h0009F, 8'h00, 3'b110, 1'b0, 8'h00, 21'h00009F, 3'b101);
		add_row(OP_IO_WR, 20'h00020, 8'h00, 3'b110, 1'b0, 8'h00, 21'h000020, 3'b111);
		add_row(OP_IO_RD, 20'h00100, 8'h00, 3'b110, 1'b0, 8'h00, 21'h000100, 3'b111);
		add_row(OP_MEM_RD, 20'h00010, 8'h5A, 3'b110, 1'b1, 8'h5A, 21'h000010, 3'b111);
		// lpt latch, then nmi mask write without tandy video
		add_row(OP_IO_WR, 20'h00378, 8'hA5, 3'b110, 1'b0, 8'h00, 21'h000378, 3'b111);
		add_row(OP_IO_RD, 20'h00378, 8'h00, 3'b110, 1'b1, 8'hA5, 21'h000378, 3'b111);
		add_row(OP_IO_WR, 20'h000A0, 8'h0C, 3'b100, 1'b0, 8'h00, 21'h0000A0, 3'b111);
		add_row(OP_IO_RD, 20'h000A0, 8'h00, 3'b110, 1'b1, 8'hFF, 21'h0000A0, 3'b111);
		// ems frame 2 at segment c: map, keep, disable
		add_row(OP_IO_WR, 20'h00262, 8'h15, 3'b110, 1'b0, 8'h00, 21'h000262, 3'b111);
		add_row(OP_MEM_RD, 20'hC8ABC, 8'h77, 3'b110, 1'b1, 8'h77, 21'h154ABC, 3'b111);
		add_row(OP_IO_RD, 20'h00262, 8'h00, 3'b110, 1'b1, 8'h15, 21'h000262, 3'b111);
		add_row(OP_IO_WR, 20'h00262, 8'h90, 3'b110, 1'b0, 8'h00, 21'h000262, 3'b111);
		add_row(OP_IO_RD, 20'h00262, 8'h00, 3'b110, 1'b1, 8'h15, 21'h000262, 3'b111);
		add_row(OP_MEM_WR, 20'hC8ABC, 8'h42, 3'b110, 1'b0, 8'h00, 21'h154ABC, 3'b110);
		add_row(OP_IO_WR, 20'h00262, 8'hFF, 3'b110, 1'b0, 8'h00, 21'h000262, 3'b111);
		add_row(OP_IO_RD, 20'h00262, 8'h00, 3'b110, 1'b1, 8'hFF, 21'h000262, 3'b111);
		add_row(OP_MEM_RD, 20'hC8ABC, 8'h19, 3'b110, 1'b1, 8'h19, 21'h0C8ABC, 3'b111);
		// tandy 16-colour paging
		add_row(OP_IO_WR, 20'h003DF, 8'h38, 3'b110, 1'b0, 8'h00, 21'h0003DF, 3'b111);
		add_row(OP_IO_WR, 20'h000A2, 8'h0A, 3'b110, 1'b0, 8'h00, 21'h0000A2, 3'b111);
		add_row(OP_MEM_RD, 20'hB8123, 8'h66, 3'b111, 1'b1, 8'h66, 21'h0BC123, 3'b111);
		add_row(OP_IO_RD, 20'h000A5, 8'h00, 3'b110, 1'b1, 8'h0A, 21'h0000A5, 3'b111);
		add_row(OP_MEM_RD, 20'hB8123, 8'h11, 3'b110, 1'b1, 8'h11, 21'h0B8123, 3'b111);
		// ram strobes, bios and rom segment excluded
		add_row(OP_MEM_WR, 20'hFE010, 8'h55, 3'b110, 1'b0, 8'h00, 21'h0FE010, 3'b111);
		add_row(OP_MEM_WR, 20'h01234, 8'h99, 3'b110, 1'b0, 8'h00, 21'h001234, 3'b110);
		add_row(OP_MEM_RD, 20'hD0000, 8'h44, 3'b110, 1'b0, 8'h00, 21'h0D0000, 3'b111);
		add_row(OP_MEM_RD, 20'hFE010, 8'h12, 3'b110, 1'b0, 8'h00, 21'h0FE010, 3'b111);
	endtask

	initial begin
		logic [31:0] rnd;
		logic [1:0] frame;
		data_t value;
		logic [13:0] low;
		data_t byte_in;
		cpu_addr_t port;
		cpu_addr_t window;

		seed = 54;
		reset = 1'b1;
		cpu_bus = make_bus(OP_IDLE, '0, '0);
		ems_enabled = 1'b1;
		// page frame at segment c
		ems_address = 2'd1;
		tandy_video = 1'b1;
		tandy_16_gfx = 1'b0;
		sram_data_in = '0;
		load_table();
		cycle_limit = 3 * (2 * (stim_table.size() + 5 * RAND_ROUNDS) + 3) + 50;
		repeat (3) @(posedge clock);
		reset <= 1'b0;

		foreach (stim_table[i])
			run_access($sformatf("row %0d", i), stim_table[i].op, stim_table[i].addr,
				stim_table[i].data, stim_table[i].mode, stim_table[i].exp_valid,
				stim_table[i].exp_data, stim_table[i].exp_addr, stim_table[i].exp_strobes);

		// random ems maps and lpt bytes, expected values from the mapping rules
		for (int r = 0; r < RAND_ROUNDS; r++) begin
			rnd = $random(seed);
			frame = rnd[1:0];
			value = {1'b0, rnd[14:8]};
			low = rnd[29:16];
			rnd = $random(seed);
			byte_in = rnd[7:0];
			port = {4'h0, EMS_PORT_BASE[15:2], frame};
			window = {4'hC, frame, low};
			run_access($sformatf("round %0d ems write", r), OP_IO_WR, port, value,
				3'b110, 1'b0, 8'h00, {1'b0, port}, 3'b111);
			run_access($sformatf("round %0d ems window", r), OP_MEM_RD, window, rnd[15:8],
				3'b110, 1'b1, rnd[15:8], {1'b1, value[5:0], low}, 3'b111);
			run_access($sformatf("round %0d ems read-back", r), OP_IO_RD, port, 8'h00,
				3'b110, 1'b1, {2'b00, value[5:0]}, {1'b0, port}, 3'b111);
			run_access($sformatf("round %0d lpt write", r), OP_IO_WR, 20'h00378, byte_in,
				3'b110, 1'b0, 8'h00, 21'h000378, 3'b111);
			run_access($sformatf("round %0d lpt read", r), OP_IO_RD, 20'h00378, 8'h00,
				3'b110, 1'b1, byte_in, 21'h000378, 3'b111);
		end

		$display("%0d tests, %0d failed, %0d check errors", tests_run, tests_failed,
			error_count);
		if (error_count == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: chipset.f
src/chipset_pkg.sv
src/io_decoder.sv
src/ems_mapper.sv
src/latch_registers.sv
src/mem_address_mapper.sv
src/bus_read_mux.sv
src/chipset_core.sv
tb/chipset_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= chipset_tb
FILELIST ?= chipset.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@! grep -q "TEST FAILED" $(LOG)
	@grep -q "TEST PASSED" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
